// ==== hdl/pagerank_pkg.sv ====
//////////////////////////////////////////////////
// Rank words in memory are already divided by out-degree
// Vertex ids and edge indices share one 24-bit width
//////////////////////////////////////////////////

package pagerank_pkg;

	localparam int VERTEX_BITS = 24;

	// Basic graph quantities
	typedef logic [VERTEX_BITS-1:0] vertex_id_t;
	typedef logic [23:0]            edge_index_t;
	typedef logic [15:0]            degree_t;

	// Unsigned fixed point, wraps modulo 2^32
	typedef logic [31:0] rank_t;

	// Status counter width
	typedef logic [31:0] count_t;

	// Tags both read commands and read responses
	typedef enum logic {
		WORD_EDGE = 1'b0,
		WORD_RANK = 1'b1
	} word_kind_e;

	// Edge array entry
	typedef struct packed {
		logic [7:0] reserved;
		vertex_id_t src_vertex;
	} edge_entry_t;

	// One memory word, decoded by its kind tag
	typedef union packed {
		edge_entry_t edge_entry;
		rank_t       rank;
	} graph_word_t;

endpackage

// ==== hdl/lane_dispatch.sv ====
//////////////////////////////////////////////////
// Jobs go to the lowest-numbered idle lane
// Only one response per lane may sit in the register
//////////////////////////////////////////////////
`timescale 1ns/100ps

module lane_dispatch #(
	parameter int NUM_LANES = 4,
	localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_valid,
	output logic                       job_ready,
	input  pagerank_pkg::vertex_id_t   job_vertex,
	input  pagerank_pkg::edge_index_t  job_edge_offset,
	input  pagerank_pkg::degree_t      job_degree,
	input  logic                       rsp_valid,
	output logic                       rsp_ready,
	input  pagerank_pkg::word_kind_e   rsp_kind,
	input  logic [LANE_BITS-1:0]       rsp_lane,
	input  pagerank_pkg::graph_word_t  rsp_word,
	input  logic [NUM_LANES-1:0]       lane_idle,
	input  logic [NUM_LANES-1:0]       lane_rsp_accept,
	output logic [NUM_LANES-1:0]       lane_job_valid,
	output pagerank_pkg::vertex_id_t   job_vertex_out,
	output pagerank_pkg::edge_index_t  job_edge_offset_out,
	output pagerank_pkg::degree_t      job_degree_out,
	output logic [NUM_LANES-1:0]       lane_rsp_valid,
	output pagerank_pkg::word_kind_e   rsp_kind_out,
	output pagerank_pkg::graph_word_t  rsp_word_out,
	output pagerank_pkg::count_t       edge_count
);
	import pagerank_pkg::*;

	logic [NUM_LANES-1:0] idle_lowest;
	logic                 accept_sel;
	logic                 rsp_q_valid;
	logic [LANE_BITS-1:0] rsp_q_lane;

	//////////////////////////////////////////////////
	// Job hand-off
	//////////////////////////////////////////////////

	assign job_ready = |lane_idle;
	// Lowest set bit of the idle mask
	assign idle_lowest    = lane_idle & (~lane_idle + 1'b1);
	assign lane_job_valid = job_valid ? idle_lowest : '0;

	assign job_vertex_out      = job_vertex;
	assign job_edge_offset_out = job_edge_offset;
	assign job_degree_out      = job_degree;

	//////////////////////////////////////////////////
	// Response routing
	//////////////////////////////////////////////////

	always_comb begin
		accept_sel = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (rsp_lane == LANE_BITS'(i)) begin
				accept_sel = lane_rsp_accept[i];
			end
		end
	end

	// Lane accept lags by a cycle, so block a lane with one in flight
	assign rsp_ready = accept_sel && !(rsp_q_valid && rsp_q_lane == rsp_lane);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_q_valid <= 1'b0;
			edge_count  <= '0;
		end else begin
			rsp_q_valid <= rsp_valid && rsp_ready;
			if (rsp_valid && rsp_ready && rsp_kind == WORD_RANK) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_valid && rsp_ready) begin
			rsp_q_lane   <= rsp_lane;
			rsp_kind_out <= rsp_kind;
			rsp_word_out <= rsp_word;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			lane_rsp_valid[i] = rsp_q_valid && rsp_q_lane == LANE_BITS'(i);
		end
	end

endmodule

// ==== hdl/vertex_lane.sv ====
//////////////////////////////////////////////////
// Holds one returned edge entry at most
// A stalled edge read keeps its slot over a new rank read
//////////////////////////////////////////////////
`timescale 1ns/100ps

module vertex_lane (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_valid,
	input  pagerank_pkg::vertex_id_t   job_vertex,
	input  pagerank_pkg::edge_index_t  job_edge_offset,
	input  pagerank_pkg::degree_t      job_degree,
	input  logic                       rsp_valid,
	input  pagerank_pkg::word_kind_e   rsp_kind,
	input  pagerank_pkg::graph_word_t  rsp_word,
	input  logic                       cmd_ready,
	input  logic                       res_ready,
	output logic                       idle,
	output logic                       rsp_accept,
	output logic                       cmd_valid,
	output pagerank_pkg::word_kind_e   cmd_kind,
	output pagerank_pkg::edge_index_t  cmd_index,
	output logic                       res_valid,
	output pagerank_pkg::vertex_id_t   res_vertex,
	output pagerank_pkg::rank_t        res_sum
);
	import pagerank_pkg::*;

	localparam logic [1:0] LANE_IDLE = 2'd0;
	localparam logic [1:0] LANE_WALK = 2'd1;
	localparam logic [1:0] LANE_DONE = 2'd2;

	logic [1:0]  state;
	vertex_id_t  vertex_q;
	edge_index_t offset_q;
	degree_t     degree_q;
	degree_t     edges_issued;
	degree_t     ranks_seen;
	logic        pend_valid;
	vertex_id_t  pend_src;
	logic        stall_edge;
	rank_t       sum_q;
	logic        edge_fire;
	logic        rank_fire;
	logic        rsp_edge;
	logic        rsp_rank;

	assign idle       = state == LANE_IDLE;
	assign rsp_accept = (state == LANE_WALK) && !pend_valid;
	assign res_valid  = state == LANE_DONE;
	assign res_vertex = vertex_q;
	assign res_sum    = sum_q;

	//////////////////////////////////////////////////
	// Command choice
	//////////////////////////////////////////////////

	assign cmd_valid = (state == LANE_WALK) && (pend_valid || edges_issued != degree_q);
	// Rank read first unless an edge read is already waiting on the port
	assign cmd_kind  = (pend_valid && !stall_edge) ? WORD_RANK : WORD_EDGE;
	assign cmd_index = (cmd_kind == WORD_RANK) ? edge_index_t'(pend_src)
		: offset_q + edge_index_t'(edges_issued);

	assign edge_fire = cmd_valid && cmd_ready && cmd_kind == WORD_EDGE;
	assign rank_fire = cmd_valid && cmd_ready && cmd_kind == WORD_RANK;
	assign rsp_edge  = rsp_valid && rsp_kind == WORD_EDGE;
	assign rsp_rank  = rsp_valid && rsp_kind == WORD_RANK;

	//////////////////////////////////////////////////
	// Lane FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= LANE_IDLE;
			edges_issued <= '0;
			ranks_seen   <= '0;
			pend_valid   <= 1'b0;
			stall_edge   <= 1'b0;
		end else begin
			case (state)
				LANE_IDLE: begin
					if (job_valid) begin
						edges_issued <= '0;
						ranks_seen   <= '0;
						pend_valid   <= 1'b0;
						stall_edge   <= 1'b0;
						state        <= (job_degree == '0) ? LANE_DONE : LANE_WALK;
					end
				end
				LANE_WALK: begin
					stall_edge <= cmd_valid && !cmd_ready && cmd_kind == WORD_EDGE;
					if (edge_fire) begin
						edges_issued <= edges_issued + 1'b1;
					end
					if (rsp_edge) begin
						pend_valid <= 1'b1;
					end else if (rank_fire) begin
						pend_valid <= 1'b0;
					end
					if (rsp_rank) begin
						ranks_seen <= ranks_seen + 1'b1;
						// Last contribution in
						if (ranks_seen + 1'b1 == degree_q) begin
							state <= LANE_DONE;
						end
					end
				end
				LANE_DONE: begin
					if (res_ready) begin
						state <= LANE_IDLE;
					end
				end
				default: state <= LANE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (idle && job_valid) begin
			vertex_q <= job_vertex;
			offset_q <= job_edge_offset;
			degree_q <= job_degree;
			sum_q    <= '0;
		end else if (rsp_rank) begin
			sum_q <= sum_q + rsp_word.rank;
		end
		if (rsp_edge) begin
			pend_src <= rsp_word.edge_entry.src_vertex;
		end
	end

endmodule

// ==== hdl/memory_port_arbiter.sv ====
//////////////////////////////////////////////////
// Round-robin over lane commands and lane results
// A stalled winner keeps the grant until it transfers
//////////////////////////////////////////////////
`timescale 1ns/100ps

module memory_port_arbiter #(
	parameter int NUM_LANES = 4,
	localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                                      clock,
	input  logic                                      rstn,
	input  logic [NUM_LANES-1:0]                      lane_cmd_valid,
	input  pagerank_pkg::word_kind_e  [NUM_LANES-1:0] lane_cmd_kind,
	input  pagerank_pkg::edge_index_t [NUM_LANES-1:0] lane_cmd_index,
	input  logic [NUM_LANES-1:0]                      lane_res_valid,
	input  pagerank_pkg::vertex_id_t  [NUM_LANES-1:0] lane_res_vertex,
	input  pagerank_pkg::rank_t       [NUM_LANES-1:0] lane_res_sum,
	input  logic                                      cmd_ready,
	input  logic                                      res_ready,
	output logic [NUM_LANES-1:0]                      lane_cmd_grant,
	output logic [NUM_LANES-1:0]                      lane_res_grant,
	output logic                                      cmd_valid,
	output pagerank_pkg::word_kind_e                  cmd_kind,
	output logic [LANE_BITS-1:0]                      cmd_lane,
	output pagerank_pkg::edge_index_t                 cmd_index,
	output logic                                      res_valid,
	output pagerank_pkg::vertex_id_t                  res_vertex,
	output pagerank_pkg::rank_t                       res_sum,
	output pagerank_pkg::count_t                      vertex_count
);

	logic [LANE_BITS-1:0] cmd_ptr;
	logic [LANE_BITS-1:0] res_ptr;
	logic [LANE_BITS-1:0] cmd_sel;
	logic [LANE_BITS-1:0] res_sel;

	// First requester at or after the pointer
	function automatic logic [LANE_BITS-1:0] rr_pick(
		input logic [NUM_LANES-1:0] req,
		input logic [LANE_BITS-1:0] ptr
	);
		logic [LANE_BITS-1:0] pick;
		int                   idx;
		pick = ptr;
		for (int k = NUM_LANES - 1; k >= 0; k--) begin
			idx = int'(ptr) + k;
			if (idx >= NUM_LANES) begin
				idx = idx - NUM_LANES;
			end
			if (req[idx]) begin
				pick = LANE_BITS'(idx);
			end
		end
		return pick;
	endfunction

	// Past the winner on transfer, parked on it while stalled
	function automatic logic [LANE_BITS-1:0] ptr_next(
		input logic [LANE_BITS-1:0] ptr,
		input logic [LANE_BITS-1:0] sel,
		input logic                 valid,
		input logic                 ready
	);
		logic [LANE_BITS-1:0] nxt;
		nxt = ptr;
		if (valid && ready) begin
			nxt = (int'(sel) == NUM_LANES - 1) ? '0 : sel + 1'b1;
		end else if (valid) begin
			nxt = sel;
		end
		return nxt;
	endfunction

	//////////////////////////////////////////////////
	// Command and result selection
	//////////////////////////////////////////////////

	assign cmd_sel        = rr_pick(lane_cmd_valid, cmd_ptr);
	assign cmd_valid      = lane_cmd_valid[cmd_sel];
	assign cmd_kind       = lane_cmd_kind[cmd_sel];
	assign cmd_index      = lane_cmd_index[cmd_sel];
	assign cmd_lane       = cmd_sel;
	assign lane_cmd_grant = (cmd_valid && cmd_ready) ? (NUM_LANES'(1) << cmd_sel) : '0;

	assign res_sel        = rr_pick(lane_res_valid, res_ptr);
	assign res_valid      = lane_res_valid[res_sel];
	assign res_vertex     = lane_res_vertex[res_sel];
	assign res_sum        = lane_res_sum[res_sel];
	assign lane_res_grant = (res_valid && res_ready) ? (NUM_LANES'(1) << res_sel) : '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_ptr      <= '0;
			res_ptr      <= '0;
			vertex_count <= '0;
		end else begin
			cmd_ptr <= ptr_next(cmd_ptr, cmd_sel, cmd_valid, cmd_ready);
			res_ptr <= ptr_next(res_ptr, res_sel, res_valid, res_ready);
			if (res_valid && res_ready) begin
				vertex_count <= vertex_count + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/pagerank_unit.sv ====
//////////////////////////////////////////////////
// Memory must echo the kind and lane of each command
//////////////////////////////////////////////////
`timescale 1ns/100ps

module pagerank_unit #(
	parameter int NUM_LANES = 4,
	localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_valid,
	output logic                       job_ready,
	input  pagerank_pkg::vertex_id_t   job_vertex,
	input  pagerank_pkg::edge_index_t  job_edge_offset,
	input  pagerank_pkg::degree_t      job_degree,
	output logic                       cmd_valid,
	input  logic                       cmd_ready,
	output pagerank_pkg::word_kind_e   cmd_kind,
	output logic [LANE_BITS-1:0]       cmd_lane,
	output pagerank_pkg::edge_index_t  cmd_index,
	input  logic                       rsp_valid,
	output logic                       rsp_ready,
	input  pagerank_pkg::word_kind_e   rsp_kind,
	input  logic [LANE_BITS-1:0]       rsp_lane,
	input  pagerank_pkg::graph_word_t  rsp_word,
	output logic                       res_valid,
	input  logic                       res_ready,
	output pagerank_pkg::vertex_id_t   res_vertex,
	output pagerank_pkg::rank_t        res_sum,
	output pagerank_pkg::count_t       vertex_count,
	output pagerank_pkg::count_t       edge_count
);
	import pagerank_pkg::*;

	logic [NUM_LANES-1:0]        lane_idle;
	logic [NUM_LANES-1:0]        lane_rsp_accept;
	logic [NUM_LANES-1:0]        lane_job_valid;
	logic [NUM_LANES-1:0]        lane_rsp_valid;
	logic [NUM_LANES-1:0]        lane_cmd_valid;
	logic [NUM_LANES-1:0]        lane_cmd_grant;
	logic [NUM_LANES-1:0]        lane_res_valid;
	logic [NUM_LANES-1:0]        lane_res_grant;
	word_kind_e  [NUM_LANES-1:0] lane_cmd_kind;
	edge_index_t [NUM_LANES-1:0] lane_cmd_index;
	vertex_id_t  [NUM_LANES-1:0] lane_res_vertex;
	rank_t       [NUM_LANES-1:0] lane_res_sum;
	vertex_id_t                  job_vertex_d;
	edge_index_t                 job_edge_offset_d;
	degree_t                     job_degree_d;
	word_kind_e                  rsp_kind_d;
	graph_word_t                 rsp_word_d;

	lane_dispatch #(.NUM_LANES(NUM_LANES)) lane_dispatch_inst (
		.clock              (clock),
		.rstn               (rstn),
		.job_valid          (job_valid),
		.job_ready          (job_ready),
		.job_vertex         (job_vertex),
		.job_edge_offset    (job_edge_offset),
		.job_degree         (job_degree),
		.rsp_valid          (rsp_valid),
		.rsp_ready          (rsp_ready),
		.rsp_kind           (rsp_kind),
		.rsp_lane           (rsp_lane),
		.rsp_word           (rsp_word),
		.lane_idle          (lane_idle),
		.lane_rsp_accept    (lane_rsp_accept),
		.lane_job_valid     (lane_job_valid),
		.job_vertex_out     (job_vertex_d),
		.job_edge_offset_out(job_edge_offset_d),
		.job_degree_out     (job_degree_d),
		.lane_rsp_valid     (lane_rsp_valid),
		.rsp_kind_out       (rsp_kind_d),
		.rsp_word_out       (rsp_word_d),
		.edge_count         (edge_count)
	);

	//////////////////////////////////////////////////
	// Vertex lanes
	//////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		vertex_lane vertex_lane_inst (
			.clock          (clock),
			.rstn           (rstn),
			.job_valid      (lane_job_valid[i]),
			.job_vertex     (job_vertex_d),
			.job_edge_offset(job_edge_offset_d),
			.job_degree     (job_degree_d),
			.rsp_valid      (lane_rsp_valid[i]),
			.rsp_kind       (rsp_kind_d),
			.rsp_word       (rsp_word_d),
			.cmd_ready      (lane_cmd_grant[i]),
			.res_ready      (lane_res_grant[i]),
			.idle           (lane_idle[i]),
			.rsp_accept     (lane_rsp_accept[i]),
			.cmd_valid      (lane_cmd_valid[i]),
			.cmd_kind       (lane_cmd_kind[i]),
			.cmd_index      (lane_cmd_index[i]),
			.res_valid      (lane_res_valid[i]),
			.res_vertex     (lane_res_vertex[i]),
			.res_sum        (lane_res_sum[i])
		);
	end

	memory_port_arbiter #(.NUM_LANES(NUM_LANES)) memory_port_arbiter_inst (
		.clock          (clock),
		.rstn           (rstn),
		.lane_cmd_valid (lane_cmd_valid),
		.lane_cmd_kind  (lane_cmd_kind),
		.lane_cmd_index (lane_cmd_index),
		.lane_res_valid (lane_res_valid),
		.lane_res_vertex(lane_res_vertex),
		.lane_res_sum   (lane_res_sum),
		.cmd_ready      (cmd_ready),
		.res_ready      (res_ready),
		.lane_cmd_grant (lane_cmd_grant),
		.lane_res_grant (lane_res_grant),
		.cmd_valid      (cmd_valid),
		.cmd_kind       (cmd_kind),
		.cmd_lane       (cmd_lane),
		.cmd_index      (cmd_index),
		.res_valid      (res_valid),
		.res_vertex     (res_vertex),
		.res_sum        (res_sum),
		.vertex_count   (vertex_count)
	);

endmodule

// ==== bench/pagerank_unit_assertions.sv ====
//////////////////////////////////////////////////
// Payloads arrive packed flat from the bind
//////////////////////////////////////////////////
`timescale 1ns/100ps

module pagerank_unit_assertions #(
	parameter int LANE_BITS = 2
) (
	input logic                  clock,
	input logic                  rstn,
	input logic                  job_valid,
	input logic                  job_ready,
	input logic [63:0]           job_payload,
	input logic                  cmd_valid,
	input logic                  cmd_ready,
	input logic [LANE_BITS+24:0] cmd_payload,
	input logic                  rsp_valid,
	input logic                  rsp_ready,
	input logic [LANE_BITS+32:0] rsp_payload,
	input logic                  res_valid,
	input logic                  res_ready,
	input logic [55:0]           res_payload
);

	// Stalled transfers hold valid and payload
	job_hold: assert property (@(posedge clock) disable iff (!rstn)
		job_valid && !job_ready |=> job_valid && $stable(job_payload))
		else $error("Job payload changed while stalled");

	cmd_hold: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_payload))
		else $error("Command payload changed while stalled");

	rsp_hold: assert property (@(posedge clock) disable iff (!rstn)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_payload))
		else $error("Response payload changed while stalled");

	res_hold: assert property (@(posedge clock) disable iff (!rstn)
		res_valid && !res_ready |=> res_valid && $stable(res_payload))
		else $error("Result payload changed while stalled");

	// Quiet outputs in reset
	reset_quiet: assert property (@(posedge clock) !rstn |-> !cmd_valid && !res_valid)
		else $error("Command or result valid during reset");

endmodule

bind pagerank_unit pagerank_unit_assertions #(.LANE_BITS(LANE_BITS)) pagerank_unit_assertions_inst (
	.clock      (clock),
	.rstn       (rstn),
	.job_valid  (job_valid),
	.job_ready  (job_ready),
	.job_payload({job_vertex, job_edge_offset, job_degree}),
	.cmd_valid  (cmd_valid),
	.cmd_ready  (cmd_ready),
	.cmd_payload({cmd_kind, cmd_lane, cmd_index}),
	.rsp_valid  (rsp_valid),
	.rsp_ready  (rsp_ready),
	.rsp_payload({rsp_kind, rsp_lane, rsp_word}),
	.res_valid  (res_valid),
	.res_ready  (res_ready),
	.res_payload({res_vertex, res_sum})
);

// ==== bench/pagerank_unit_tb.sv ====
//////////////////////////////////////////////////
// Memory model answers reads in random order
// Vertex ids in the job table must be distinct
//////////////////////////////////////////////////
`timescale 1ns/100ps

module pagerank_unit_tb;
	import pagerank_pkg::*;

	localparam int NUM_LANES = 4;
	localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int EDGE_SIZE = 48;
	localparam int RANK_SIZE = 128;
	localparam int NUM_JOBS  = 9;

	logic                 clock;
	logic                 rstn;
	logic                 job_valid;
	logic                 job_ready;
	vertex_id_t           job_vertex;
	edge_index_t          job_edge_offset;
	degree_t              job_degree;
	logic                 cmd_valid;
	logic                 cmd_ready;
	word_kind_e           cmd_kind;
	logic [LANE_BITS-1:0] cmd_lane;
	edge_index_t          cmd_index;
	logic                 rsp_valid;
	logic                 rsp_ready;
	word_kind_e           rsp_kind;
	logic [LANE_BITS-1:0] rsp_lane;
	graph_word_t          rsp_word;
	logic                 res_valid;
	logic                 res_ready;
	vertex_id_t           res_vertex;
	rank_t                res_sum;
	count_t               vertex_count;
	count_t               edge_count;

	// Graph memory and the job table
	graph_word_t edge_mem   [EDGE_SIZE];
	rank_t       rank_mem   [RANK_SIZE];
	vertex_id_t  tab_vertex [NUM_JOBS];
	edge_index_t tab_offset [NUM_JOBS];
	degree_t     tab_degree [NUM_JOBS];
	rank_t       tab_sum    [NUM_JOBS];
	logic        pending    [NUM_JOBS];

	// Responses queued in the memory model
	word_kind_e           rspq_kind [$];
	logic [LANE_BITS-1:0] rspq_lane [$];
	graph_word_t          rspq_word [$];

	integer seed;
	logic   random_mode;
	logic   no_cmd_expected;
	logic   rsp_taken;
	int     results_seen;
	int     results_expected;
	int     edges_expected;

	pagerank_unit #(.NUM_LANES(NUM_LANES)) pagerank_unit_inst (.*);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_result(input vertex_id_t got_vertex, input rank_t got_sum,
		input vertex_id_t exp_vertex, input rank_t exp_sum);
		if (got_vertex !== exp_vertex) begin
			fail_now($sformatf("Mismatch res_vertex: got %h expected %h", got_vertex, exp_vertex));
		end else if (got_sum !== exp_sum) begin
			fail_now($sformatf("Mismatch res_sum for vertex %h: got %h expected %h",
				got_vertex, got_sum, exp_sum));
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_command(input word_kind_e kind, input edge_index_t index);
		if (kind == WORD_EDGE && int'(index) >= EDGE_SIZE) begin
			fail_now($sformatf("Edge read at index %h lies outside the edge array", index));
		end else if (kind == WORD_RANK && int'(index) >= RANK_SIZE) begin
			fail_now($sformatf("Rank read at index %h lies outside the rank array", index));
		end
	endtask

	task automatic fill_memory();
		graph_word_t w;
		for (int i = 0; i < EDGE_SIZE; i++) begin
			// Reserved bits set so the lane must ignore them
			w.edge_entry.reserved   = 8'(i) ^ 8'hA5;
			w.edge_entry.src_vertex = vertex_id_t'((i * 37 + 11) % RANK_SIZE);
			edge_mem[i] = w;
		end
		for (int v = 0; v < RANK_SIZE; v++) begin
			// Large values so sums wrap
			rank_mem[v] = rank_t'(v + 1) * 32'h9E37_79B1;
		end
	endtask

	task automatic add_job(input int j, input vertex_id_t v, input edge_index_t off,
		input degree_t deg);
		rank_t       sum;
		graph_word_t e;
		sum = '0;
		for (int k = 0; k < int'(deg); k++) begin
			e   = edge_mem[int'(off) + k];
			sum = sum + rank_mem[int'(e.edge_entry.src_vertex)];
		end
		tab_vertex[j] = v;
		tab_offset[j] = off;
		tab_degree[j] = deg;
		tab_sum[j]    = sum;
		pending[j]    = 1'b0;
	endtask

	task automatic apply_job(input int j);
		@(negedge clock);
		job_valid       = 1'b1;
		job_vertex      = tab_vertex[j];
		job_edge_offset = tab_offset[j];
		job_degree      = tab_degree[j];
		#1;
		while (!job_ready) begin
			@(negedge clock);
			#1;
		end
		pending[j] = 1'b1;
		results_expected++;
		edges_expected += int'(tab_degree[j]);
	endtask

	task automatic end_jobs();
		@(negedge clock);
		job_valid = 1'b0;
	endtask

	task automatic wait_results();
		wait (results_seen == results_expected);
		repeat (2) @(negedge clock);
		check_count("vertex_count", vertex_count, count_t'(results_expected));
		check_count("edge_count", edge_count, count_t'(edges_expected));
	endtask

	task automatic record_command();
		graph_word_t w;
		if (no_cmd_expected) begin
			fail_now("Read command issued while only a degree-zero job was running");
		end
		check_command(cmd_kind, cmd_index);
		if (cmd_kind == WORD_EDGE) begin
			w = edge_mem[int'(cmd_index)];
		end else begin
			w.rank = rank_mem[int'(cmd_index)];
		end
		rspq_kind.push_back(cmd_kind);
		rspq_lane.push_back(cmd_lane);
		rspq_word.push_back(w);
	endtask

	task automatic take_result();
		int found;
		int first;
		found = -1;
		first = -1;
		for (int j = 0; j < NUM_JOBS; j++) begin
			if (pending[j]) begin
				if (first < 0) begin
					first = j;
				end
				if (tab_vertex[j] == res_vertex) begin
					found = j;
				end
			end
		end
		if (first < 0) begin
			fail_now($sformatf("Result for vertex %h arrived with no job outstanding",
				res_vertex));
		end else begin
			// Unknown vertex is compared against the oldest outstanding job
			if (found < 0) begin
				found = first;
			end
			check_result(res_vertex, res_sum, tab_vertex[found], tab_sum[found]);
			pending[found] = 1'b0;
			results_seen++;
		end
	endtask

	//////////////////////////////////////////////////
	// Memory model and port monitor
	//////////////////////////////////////////////////

	always @(negedge clock) begin : memory_model
		int pick;
		if (rstn) begin
			cmd_ready = random_mode ? (($random(seed) & 3) != 0) : 1'b1;
			res_ready = random_mode ? (($random(seed) & 3) != 0) : 1'b1;
			if (rsp_taken) begin
				rsp_valid = 1'b0;
			end
			if (!rsp_valid && rspq_kind.size() > 0
				&& (!random_mode || ($random(seed) & 1) != 0)) begin
				pick     = ($random(seed) & 32'h7fff_ffff) % rspq_kind.size();
				rsp_kind = rspq_kind[pick];
				rsp_lane = rspq_lane[pick];
				rsp_word = rspq_word[pick];
				rspq_kind.delete(pick);
				rspq_lane.delete(pick);
				rspq_word.delete(pick);
				rsp_valid = 1'b1;
			end
			// Sample what transfers on the next rising edge
			#1;
			rsp_taken = rsp_valid && rsp_ready;
			if (cmd_valid && cmd_ready) begin
				record_command();
			end
			if (res_valid && res_ready) begin
				take_result();
			end
		end
	end

	initial begin : watchdog
		int total_degree;
		int limit;
		total_degree = 0;
		wait (rstn === 1'b1);
		for (int j = 0; j < NUM_JOBS; j++) begin
			total_degree += int'(tab_degree[j]);
		end
		// Room for four passes over the table with slack per edge and per job
		limit = 4 * (total_degree * 40 + NUM_JOBS * 20) + 100;
		repeat (limit) @(posedge clock);
		fail_now($sformatf("Timeout after %0d cycles with %0d of %0d results received",
			limit, results_seen, results_expected));
	end

	initial begin
		seed             = 32'h837a9e1b;
		rstn             = 1'b0;
		job_valid        = 1'b0;
		job_vertex       = '0;
		job_edge_offset  = '0;
		job_degree       = '0;
		cmd_ready        = 1'b0;
		rsp_valid        = 1'b0;
		rsp_kind         = WORD_EDGE;
		rsp_lane         = '0;
		rsp_word         = '0;
		res_ready        = 1'b0;
		random_mode      = 1'b0;
		no_cmd_expected  = 1'b0;
		rsp_taken        = 1'b0;
		results_seen     = 0;
		results_expected = 0;
		edges_expected   = 0;
		fill_memory();
		// Vertex, edge offset, degree
		add_job(0, 24'h000011, 24'd0, 16'd5);
		add_job(1, 24'h000022, 24'd5, 16'd3);
		add_job(2, 24'h000033, 24'd8, 16'd0);
		add_job(3, 24'h000044, 24'd8, 16'd8);
		add_job(4, 24'h000055, 24'd16, 16'd1);
		add_job(5, 24'h000066, 24'd17, 16'd12);
		add_job(6, 24'h000077, 24'd29, 16'd6);
		add_job(7, 24'h000088, 24'd35, 16'd2);
		add_job(8, 24'h000099, 24'd37, 16'd7);
		repeat (8) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// One job alone, then a degree-zero job alone
		apply_job(0);
		end_jobs();
		wait_results();
		no_cmd_expected = 1'b1;
		apply_job(2);
		end_jobs();
		wait_results();
		no_cmd_expected = 1'b0;

		// Whole table back to back
		for (int j = 0; j < NUM_JOBS; j++) begin
			apply_job(j);
		end
		end_jobs();
		wait_results();

		// Again under random back-pressure and response gaps
		random_mode = 1'b1;
		for (int j = 0; j < NUM_JOBS; j++) begin
			apply_job(j);
		end
		end_jobs();
		wait_results();

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== list.f ====
hdl/pagerank_pkg.sv
hdl/lane_dispatch.sv
hdl/vertex_lane.sv
hdl/memory_port_arbiter.sv
hdl/pagerank_unit.sv
bench/pagerank_unit_assertions.sv
bench/pagerank_unit_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module pagerank_unit_tb -f list.f
	./obj_dir/Vpagerank_unit_tb | tee sim.log
	grep -q "\*\* PASS \*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
